// File: src/vfu_pkg.sv
////////////////////
// Widths, types and operation codes of the integer vector functional unit
// All RTL refers to these through vfu_pkg:: scoped names
////////////////////

package vfu_pkg;

  // Datapath geometry
  localparam int ELEN           = 32;
  localparam int ELENB          = ELEN / 8;
  localparam int N_LANES        = 2;
  localparam int VRF_W          = ELEN * N_LANES;
  localparam int VRF_BE_W       = VRF_W / 8;
  localparam int WORDS_PER_VREG = 4;
  localparam int WORD_IDX_W     = $clog2(WORDS_PER_VREG);
  localparam int NR_VREGS       = 32;

  typedef logic [ELEN-1:0]                               elen_t;
  typedef logic [VRF_W-1:0]                              vrf_data_t;
  typedef logic [VRF_BE_W-1:0]                           vrf_be_t;
  // Register number times WORDS_PER_VREG plus the word index
  typedef logic [$clog2(NR_VREGS * WORDS_PER_VREG)-1:0]  vrf_addr_t;
  typedef logic [$clog2(NR_VREGS)-1:0]                   vreg_t;
  // Element count, up to 32 inclusive
  typedef logic [5:0]                                    vlen_t;
  typedef logic [1:0]                                    vfu_id_t;
  typedef logic [1:0]                                    sew_t;
  typedef logic [2:0]                                    vfu_op_t;

  ////////////////////
  // Element widths
  localparam sew_t SEW_8  = 2'd0;
  localparam sew_t SEW_16 = 2'd1;
  localparam sew_t SEW_32 = 2'd2;

  ////////////////////
  // Operations
  localparam vfu_op_t OP_ADD = 3'd0;
  localparam vfu_op_t OP_SUB = 3'd1;
  localparam vfu_op_t OP_AND = 3'd2;
  localparam vfu_op_t OP_OR  = 3'd3;
  localparam vfu_op_t OP_XOR = 3'd4;

  // Sequencer progress through one instruction
  typedef enum logic {
    SEQ_IDLE,
    SEQ_RUN
  } vfu_seq_state_e;

endpackage

// File: src/vfu_op_queue.sv
////////////////////
// Two-entry request queue in front of the sequencer
// Spill buffer with a registered ready, full throughput when drained
////////////////////

`timescale 1ns/1ns

module vfu_op_queue (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  vfu_pkg::vfu_id_t  in_id_i,
  input  vfu_pkg::vfu_op_t  in_op_i,
  input  vfu_pkg::sew_t     in_sew_i,
  input  vfu_pkg::vlen_t    in_vl_i,
  input  vfu_pkg::vreg_t    in_vs1_i, in_vs2_i, in_vd_i,
  input  logic              in_use_vs1_i, in_is_scalar_i,
  input  vfu_pkg::elen_t    in_rs1_i, in_rs2_i,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output vfu_pkg::vfu_id_t  out_id_o,
  output vfu_pkg::vfu_op_t  out_op_o,
  output vfu_pkg::sew_t     out_sew_o,
  output vfu_pkg::vlen_t    out_vl_o,
  output vfu_pkg::vreg_t    out_vs1_o, out_vs2_o, out_vd_o,
  output logic              out_use_vs1_o, out_is_scalar_o,
  output vfu_pkg::elen_t    out_rs1_o, out_rs2_o
);

  typedef struct packed {
    vfu_pkg::vfu_id_t id;
    vfu_pkg::vfu_op_t op;
    vfu_pkg::sew_t    sew;
    vfu_pkg::vlen_t   vl;
    vfu_pkg::vreg_t   vs1;
    vfu_pkg::vreg_t   vs2;
    vfu_pkg::vreg_t   vd;
    logic             use_vs1;
    logic             is_scalar;
    vfu_pkg::elen_t   rs1;
    vfu_pkg::elen_t   rs2;
  } req_t;

  req_t in_req, out_req, main_q, spill_q;
  logic main_full_q, spill_full_q;
  logic main_fill, main_drain, spill_fill, spill_drain;

  assign in_req = {in_id_i, in_op_i, in_sew_i, in_vl_i, in_vs1_i, in_vs2_i, in_vd_i,
                   in_use_vs1_i, in_is_scalar_i, in_rs1_i, in_rs2_i};

  assign in_ready_o = !main_full_q || !spill_full_q;
  assign main_fill  = in_valid_i && in_ready_o;
  // Main entry leaves whenever the spill entry is free
  assign main_drain  = main_full_q && !spill_full_q;
  assign spill_fill  = main_drain && !out_ready_i;
  assign spill_drain = spill_full_q && out_ready_i;

  // Spill entry is always the older one
  assign out_valid_o = main_full_q || spill_full_q;
  assign out_req     = spill_full_q ? spill_q : main_q;
  assign {out_id_o, out_op_o, out_sew_o, out_vl_o, out_vs1_o, out_vs2_o, out_vd_o,
          out_use_vs1_o, out_is_scalar_o, out_rs1_o, out_rs2_o} = out_req;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      main_full_q  <= 1'b0;
      spill_full_q <= 1'b0;
    end else begin
      main_full_q  <= main_fill || (main_full_q && !main_drain);
      spill_full_q <= spill_fill || (spill_full_q && !spill_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_fill) begin
      main_q <= in_req;
    end
    if (spill_fill) begin
      spill_q <= main_q;
    end
  end

endmodule

// File: src/vfu_sequencer.sv
////////////////////
// Steps through one instruction a VRF word at a time
// Drives the read ports, decides when a word issues and pops the queue
// on the last word. Scalar operations issue once without reads
////////////////////

`timescale 1ns/1ns

module vfu_sequencer (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         q_valid_i,
  input  vfu_pkg::sew_t                q_sew_i,
  input  vfu_pkg::vlen_t               q_vl_i,
  input  vfu_pkg::vreg_t               q_vs1_i, q_vs2_i, q_vd_i, q_rd_i,
  input  logic                         q_use_vs1_i, q_is_scalar_i,
  input  vfu_pkg::vfu_id_t             q_id_i,
  output logic                         q_pop_o,
  output logic               [1:0]     vrf_re_o,
  output vfu_pkg::vrf_addr_t [1:0]     vrf_raddr_o,
  input  logic               [1:0]     vrf_rvalid_i,
  input  logic                         wb_ready_i,
  output logic                         issue_o,
  output vfu_pkg::vfu_id_t             issue_id_o,
  output vfu_pkg::vrf_addr_t           issue_vd_addr_o,
  output logic                         issue_wb_o,
  output logic                         issue_last_o
);

  vfu_pkg::vfu_seq_state_e               state_q;
  vfu_pkg::vlen_t                        elem_cnt_q, cur_elem, elem_per_word;
  logic [vfu_pkg::WORD_IDX_W-1:0]        word_idx_q, cur_word;
  logic [$bits(vfu_pkg::vlen_t):0]       elem_next;
  logic                                  need_vs1, need_vs2, operands_ok;

  function automatic vfu_pkg::vrf_addr_t word_addr(vfu_pkg::vreg_t vreg,
                                                   logic [vfu_pkg::WORD_IDX_W-1:0] idx);
    word_addr = vfu_pkg::vrf_addr_t'(int'(vreg) * vfu_pkg::WORDS_PER_VREG + int'(idx));
  endfunction

  // Position restarts at zero for a new instruction
  always_comb begin
    unique case (state_q)
      vfu_pkg::SEQ_RUN: begin
        cur_elem = elem_cnt_q;
        cur_word = word_idx_q;
      end
      default: begin
        cur_elem = '0;
        cur_word = '0;
      end
    endcase
  end

  // Elements in one word shrink as SEW grows
  assign elem_per_word = vfu_pkg::vlen_t'((vfu_pkg::ELENB * vfu_pkg::N_LANES) >> q_sew_i);
  assign elem_next     = {1'b0, cur_elem} + {1'b0, elem_per_word};

  ////////////////////
  // Operand reads
  assign need_vs2    = q_valid_i && !q_is_scalar_i;
  assign need_vs1    = need_vs2 && q_use_vs1_i;
  assign vrf_re_o    = {need_vs1, need_vs2};
  assign vrf_raddr_o = {word_addr(q_vs1_i, cur_word), word_addr(q_vs2_i, cur_word)};
  assign operands_ok = (!need_vs2 || vrf_rvalid_i[0]) && (!need_vs1 || vrf_rvalid_i[1]);

  ////////////////////
  // Issue
  assign issue_o      = q_valid_i && operands_ok && wb_ready_i;
  assign issue_last_o = q_is_scalar_i || (elem_next >= {1'b0, q_vl_i});
  assign q_pop_o      = issue_o && issue_last_o;
  assign issue_id_o   = q_id_i;
  assign issue_wb_o   = q_is_scalar_i;
  // Scalar results carry rd in place of a VRF address
  assign issue_vd_addr_o = q_is_scalar_i ? vfu_pkg::vrf_addr_t'(q_rd_i)
                                         : word_addr(q_vd_i, cur_word);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= vfu_pkg::SEQ_IDLE;
      elem_cnt_q <= '0;
      word_idx_q <= '0;
    end else if (issue_o) begin
      state_q    <= issue_last_o ? vfu_pkg::SEQ_IDLE : vfu_pkg::SEQ_RUN;
      elem_cnt_q <= vfu_pkg::vlen_t'(elem_next);
      word_idx_q <= cur_word + 1'b1;
    end
  end

endmodule

// File: src/vfu_operand_mux.sv
////////////////////
// Picks the two operand words for the lanes
// Scalar rs1 is cut to SEW and repeated across the word
////////////////////

`timescale 1ns/1ns

module vfu_operand_mux (
  input  logic                      is_scalar_i,
  input  logic                      use_vs1_i,
  input  vfu_pkg::sew_t             sew_i,
  input  vfu_pkg::elen_t            rs1_i,
  input  vfu_pkg::elen_t            rs2_i,
  input  vfu_pkg::vrf_data_t [1:0]  vrf_rdata_i,
  output vfu_pkg::vrf_data_t        op1_o,
  output vfu_pkg::vrf_data_t        op2_o
);

  // vs2 word, or rs2 in lane 0 for scalar operations
  assign op2_o = is_scalar_i ? vfu_pkg::vrf_data_t'(rs2_i) : vrf_rdata_i[0];

  always_comb begin
    if (is_scalar_i) begin
      op1_o = vfu_pkg::vrf_data_t'(rs1_i);
    end else if (use_vs1_i) begin
      op1_o = vrf_rdata_i[1];
    end else begin
      // Splat the scalar over every element
      unique case (sew_i)
        vfu_pkg::SEW_8:  op1_o = {(vfu_pkg::VRF_W / 8){rs1_i[7:0]}};
        vfu_pkg::SEW_16: op1_o = {(vfu_pkg::VRF_W / 16){rs1_i[15:0]}};
        default:         op1_o = {vfu_pkg::N_LANES{rs1_i}};
      endcase
    end
  end

endmodule

// File: src/vfu_simd_alu.sv
////////////////////
// One integer lane over an ELEN slice
// Packed add/sub/logic at 8, 16 or 32 bit elements, purely combinational
////////////////////

`timescale 1ns/1ns

module vfu_simd_alu (
  input  vfu_pkg::vfu_op_t op_i,
  input  vfu_pkg::sew_t    sew_i,
  input  vfu_pkg::elen_t   a_i,
  input  vfu_pkg::elen_t   b_i,
  output vfu_pkg::elen_t   result_o
);

  logic                        is_sub;
  logic [vfu_pkg::ELENB-1:0]   elem_start;
  vfu_pkg::elen_t              a_op, sum;

  // vsub is vs2 minus vs1, so b + ~a + 1
  assign is_sub = (op_i == vfu_pkg::OP_SUB);
  assign a_op   = is_sub ? ~a_i : a_i;

  // Bytes that begin an element
  always_comb begin
    int step;
    step = 1 << sew_i;
    for (int i = 0; i < vfu_pkg::ELENB; i++) begin
      elem_start[i] = (i % step) == 0;
    end
  end

  // Byte-wide ripple, carry restarts at each element boundary
  always_comb begin
    logic [8:0] byte_sum;
    logic       carry;
    carry    = 1'b0;
    byte_sum = '0;
    for (int i = 0; i < vfu_pkg::ELENB; i++) begin
      if (elem_start[i]) begin
        carry = is_sub;
      end
      byte_sum      = {1'b0, b_i[8*i +: 8]} + {1'b0, a_op[8*i +: 8]} + {8'd0, carry};
      sum[8*i +: 8] = byte_sum[7:0];
      carry         = byte_sum[8];
    end
  end

  always_comb begin
    unique case (op_i)
      vfu_pkg::OP_ADD,
      vfu_pkg::OP_SUB: result_o = sum;
      vfu_pkg::OP_AND: result_o = a_i & b_i;
      vfu_pkg::OP_OR:  result_o = a_i | b_i;
      vfu_pkg::OP_XOR: result_o = a_i ^ b_i;
      default:         result_o = '0;
    endcase
  end

endmodule

// File: src/vfu_writeback.sv
////////////////////
// Single-word result buffer between the lanes and the outside
// Vector words go to the VRF write port, scalars to the response channel.
// Loads at issue and can drain in the same cycle
////////////////////

`timescale 1ns/1ns

module vfu_writeback (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                issue_i,
  input  vfu_pkg::vfu_id_t    issue_id_i,
  input  vfu_pkg::vrf_addr_t  issue_vd_addr_i,
  input  logic                issue_wb_i,
  input  logic                issue_last_i,
  input  vfu_pkg::vrf_data_t  alu_result_i,
  output logic                wb_ready_o,
  output logic                vrf_we_o,
  output vfu_pkg::vrf_addr_t  vrf_waddr_o,
  output vfu_pkg::vrf_data_t  vrf_wdata_o,
  output vfu_pkg::vrf_be_t    vrf_wbe_o,
  input  logic                vrf_wvalid_i,
  output logic                rsp_valid_o,
  output vfu_pkg::vfu_id_t    rsp_id_o,
  output logic                rsp_wb_o,
  output vfu_pkg::vreg_t      rsp_rd_o,
  output vfu_pkg::elen_t      rsp_result_o,
  input  logic                rsp_ready_i
);

  logic                full_q, drain;
  vfu_pkg::vrf_data_t  data_q;
  vfu_pkg::vfu_id_t    id_q;
  vfu_pkg::vrf_addr_t  vd_addr_q;
  logic                wb_q, last_q;

  // Buffer empties on the write ack or on response acceptance
  assign drain      = full_q && (wb_q ? rsp_ready_i : vrf_wvalid_i);
  assign wb_ready_o = !full_q || drain;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (issue_i) begin
      full_q <= 1'b1;
    end else if (drain) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      data_q    <= alu_result_i;
      id_q      <= issue_id_i;
      vd_addr_q <= issue_vd_addr_i;
      wb_q      <= issue_wb_i;
      last_q    <= issue_last_i;
    end
  end

  // VRF write, whole word
  assign vrf_we_o    = full_q && !wb_q;
  assign vrf_waddr_o = vd_addr_q;
  assign vrf_wdata_o = data_q;
  assign vrf_wbe_o   = '1;

  // Scalar result held until taken, vector completion pulses with the last ack
  assign rsp_valid_o  = full_q && (wb_q || (last_q && vrf_wvalid_i));
  assign rsp_id_o     = id_q;
  assign rsp_wb_o     = wb_q;
  assign rsp_rd_o     = vfu_pkg::vreg_t'(vd_addr_q);
  assign rsp_result_o = data_q[vfu_pkg::ELEN-1:0];

endmodule

// File: src/vfu_top.sv
////////////////////
// Integer vector functional unit
// Request queue, word sequencer, operand mux, N_LANES SIMD lanes and the
// writeback buffer, with VRF read and write ports toward the register file
////////////////////

`timescale 1ns/1ns

module vfu_top (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  input  vfu_pkg::vfu_id_t             req_id_i,
  input  vfu_pkg::vfu_op_t             req_op_i,
  input  vfu_pkg::sew_t                req_sew_i,
  input  vfu_pkg::vlen_t               req_vl_i,
  input  vfu_pkg::vreg_t               req_vs1_i, req_vs2_i, req_vd_i,
  input  logic                         req_use_vs1_i, req_is_scalar_i,
  input  vfu_pkg::elen_t               req_rs1_i, req_rs2_i,
  output logic               [1:0]     vrf_re_o,
  output vfu_pkg::vrf_addr_t [1:0]     vrf_raddr_o,
  input  vfu_pkg::vrf_data_t [1:0]     vrf_rdata_i,
  input  logic               [1:0]     vrf_rvalid_i,
  output logic                         vrf_we_o,
  output vfu_pkg::vrf_addr_t           vrf_waddr_o,
  output vfu_pkg::vrf_data_t           vrf_wdata_o,
  output vfu_pkg::vrf_be_t             vrf_wbe_o,
  input  logic                         vrf_wvalid_i,
  output logic                         rsp_valid_o,
  output vfu_pkg::vfu_id_t             rsp_id_o,
  output logic                         rsp_wb_o,
  output vfu_pkg::vreg_t               rsp_rd_o,
  output vfu_pkg::elen_t               rsp_result_o,
  input  logic                         rsp_ready_i
);

  logic                q_valid, q_pop, q_use_vs1, q_is_scalar;
  vfu_pkg::vfu_id_t    q_id;
  vfu_pkg::vfu_op_t    q_op;
  vfu_pkg::sew_t       q_sew;
  vfu_pkg::vlen_t      q_vl;
  vfu_pkg::vreg_t      q_vs1, q_vs2, q_vd;
  vfu_pkg::elen_t      q_rs1, q_rs2;
  vfu_pkg::vrf_data_t  op1, op2, alu_result;
  logic                issue, issue_wb, issue_last, wb_ready;
  vfu_pkg::vfu_id_t    issue_id;
  vfu_pkg::vrf_addr_t  issue_vd_addr;

  vfu_op_queue u_op_queue (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .in_valid_i(req_valid_i), .in_ready_o(req_ready_o),
    .in_id_i(req_id_i), .in_op_i(req_op_i), .in_sew_i(req_sew_i), .in_vl_i(req_vl_i),
    .in_vs1_i(req_vs1_i), .in_vs2_i(req_vs2_i), .in_vd_i(req_vd_i),
    .in_use_vs1_i(req_use_vs1_i), .in_is_scalar_i(req_is_scalar_i),
    .in_rs1_i(req_rs1_i), .in_rs2_i(req_rs2_i),
    .out_valid_o(q_valid), .out_ready_i(q_pop),
    .out_id_o(q_id), .out_op_o(q_op), .out_sew_o(q_sew), .out_vl_o(q_vl),
    .out_vs1_o(q_vs1), .out_vs2_o(q_vs2), .out_vd_o(q_vd),
    .out_use_vs1_o(q_use_vs1), .out_is_scalar_o(q_is_scalar),
    .out_rs1_o(q_rs1), .out_rs2_o(q_rs2)
  );

  // Scalar destination register rides in the vd field
  vfu_sequencer u_sequencer (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .q_valid_i(q_valid), .q_sew_i(q_sew), .q_vl_i(q_vl),
    .q_vs1_i(q_vs1), .q_vs2_i(q_vs2), .q_vd_i(q_vd), .q_rd_i(q_vd),
    .q_use_vs1_i(q_use_vs1), .q_is_scalar_i(q_is_scalar), .q_id_i(q_id), .q_pop_o(q_pop),
    .vrf_re_o(vrf_re_o), .vrf_raddr_o(vrf_raddr_o), .vrf_rvalid_i(vrf_rvalid_i),
    .wb_ready_i(wb_ready),
    .issue_o(issue), .issue_id_o(issue_id), .issue_vd_addr_o(issue_vd_addr),
    .issue_wb_o(issue_wb), .issue_last_o(issue_last)
  );

  vfu_operand_mux u_operand_mux (
    .is_scalar_i(q_is_scalar), .use_vs1_i(q_use_vs1), .sew_i(q_sew),
    .rs1_i(q_rs1), .rs2_i(q_rs2), .vrf_rdata_i(vrf_rdata_i),
    .op1_o(op1), .op2_o(op2)
  );

  ////////////////////
  // Lanes
  for (genvar lane = 0; lane < vfu_pkg::N_LANES; lane++) begin : gen_lanes
    vfu_simd_alu u_simd_alu (
      .op_i(q_op), .sew_i(q_sew),
      .a_i(op1[lane*vfu_pkg::ELEN +: vfu_pkg::ELEN]),
      .b_i(op2[lane*vfu_pkg::ELEN +: vfu_pkg::ELEN]),
      .result_o(alu_result[lane*vfu_pkg::ELEN +: vfu_pkg::ELEN])
    );
  end

  vfu_writeback u_writeback (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .issue_i(issue), .issue_id_i(issue_id), .issue_vd_addr_i(issue_vd_addr),
    .issue_wb_i(issue_wb), .issue_last_i(issue_last),
    .alu_result_i(alu_result), .wb_ready_o(wb_ready),
    .vrf_we_o(vrf_we_o), .vrf_waddr_o(vrf_waddr_o), .vrf_wdata_o(vrf_wdata_o),
    .vrf_wbe_o(vrf_wbe_o), .vrf_wvalid_i(vrf_wvalid_i),
    .rsp_valid_o(rsp_valid_o), .rsp_id_o(rsp_id_o), .rsp_wb_o(rsp_wb_o),
    .rsp_rd_o(rsp_rd_o), .rsp_result_o(rsp_result_o), .rsp_ready_i(rsp_ready_i)
  );

endmodule

// File: verif/tb_vfu.sv
////////////////////
// Directed testbench for the integer vector functional unit
// Holds a VRF model with one cycle read latency and a write acknowledge
// that can stall at random. Each test sends requests and checks the VRF
// contents and the response channel against element-wise expectations
////////////////////

`timescale 1ns/1ns

module tb_vfu;

  localparam int TIMEOUT = 400;

  logic                          clk_i, rst_n_i;
  logic                          req_valid, req_ready, req_use_vs1, req_is_scalar;
  vfu_pkg::vfu_id_t              req_id;
  vfu_pkg::vfu_op_t              req_op;
  vfu_pkg::sew_t                 req_sew;
  vfu_pkg::vlen_t                req_vl;
  vfu_pkg::vreg_t                req_vs1, req_vs2, req_vd;
  vfu_pkg::elen_t                req_rs1, req_rs2;
  logic               [1:0]      vrf_re;
  vfu_pkg::vrf_addr_t [1:0]      vrf_raddr;
  vfu_pkg::vrf_data_t [1:0]      vrf_rdata = '0;
  logic               [1:0]      vrf_rvalid = '0;
  logic                          vrf_we, rsp_valid, rsp_wb;
  logic                          vrf_wvalid = 1'b1;
  vfu_pkg::vrf_addr_t            vrf_waddr;
  vfu_pkg::vrf_data_t            vrf_wdata;
  vfu_pkg::vrf_be_t              vrf_wbe;
  vfu_pkg::vfu_id_t              rsp_id;
  vfu_pkg::vreg_t                rsp_rd;
  vfu_pkg::elen_t                rsp_result;
  logic                          rsp_ready;

  vfu_pkg::vrf_data_t            vrf_mem [128];
  vfu_pkg::vfu_id_t              cmpl_ids [$];
  logic [31:0]                   rng = 32'ha677;
  logic [31:0]                   stall_rng = 32'ha677;
  logic                          stall_en = 1'b0;
  int                            err_cnt = 0, check_cnt = 0, test_cnt = 0;

  vfu_top u_vfu_top (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_id_i(req_id),
    .req_op_i(req_op), .req_sew_i(req_sew), .req_vl_i(req_vl),
    .req_vs1_i(req_vs1), .req_vs2_i(req_vs2), .req_vd_i(req_vd),
    .req_use_vs1_i(req_use_vs1), .req_is_scalar_i(req_is_scalar),
    .req_rs1_i(req_rs1), .req_rs2_i(req_rs2),
    .vrf_re_o(vrf_re), .vrf_raddr_o(vrf_raddr), .vrf_rdata_i(vrf_rdata),
    .vrf_rvalid_i(vrf_rvalid), .vrf_we_o(vrf_we), .vrf_waddr_o(vrf_waddr),
    .vrf_wdata_o(vrf_wdata), .vrf_wbe_o(vrf_wbe), .vrf_wvalid_i(vrf_wvalid),
    .rsp_valid_o(rsp_valid), .rsp_id_o(rsp_id), .rsp_wb_o(rsp_wb),
    .rsp_rd_o(rsp_rd), .rsp_result_o(rsp_result), .rsp_ready_i(rsp_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  ////////////////////
  // VRF model and completion monitor
  always @(posedge clk_i) begin
    for (int p = 0; p < 2; p++) begin
      vrf_rvalid[p] <= vrf_re[p] && !vrf_rvalid[p];
      vrf_rdata[p]  <= vrf_mem[vrf_raddr[p]];
    end
    if (vrf_we && vrf_wvalid && vrf_wbe == '1) begin
      vrf_mem[vrf_waddr] = vrf_wdata;
    end
    if (rsp_valid && !rsp_wb) begin
      cmpl_ids.push_back(rsp_id);
    end
    // Roughly one stall in four
    if (stall_en) begin
      stall_rng = xorshift32(stall_rng);
      vrf_wvalid <= stall_rng[0] | stall_rng[7];
    end else begin
      vrf_wvalid <= 1'b1;
    end
  end

  // Element-wise reference with op1 from vs1 or the cut rs1 and op2 from vs2
  function automatic vfu_pkg::vrf_data_t expect_word(
      input vfu_pkg::vfu_op_t op, input vfu_pkg::sew_t sew, input vfu_pkg::vrf_data_t vs2,
      input vfu_pkg::vrf_data_t vs1, input logic use_vs1, input vfu_pkg::elen_t rs1);
    int          w;
    logic [63:0] mask, a, b, r, res;
    w    = 8 << sew;
    mask = (64'd1 << w) - 64'd1;
    res  = '0;
    for (int e = 0; e < 64 / w; e++) begin
      b = (vs2 >> (e * w)) & mask;
      a = use_vs1 ? ((vs1 >> (e * w)) & mask) : (64'(rs1) & mask);
      case (op)
        vfu_pkg::OP_ADD: r = b + a;
        vfu_pkg::OP_SUB: r = b - a;
        vfu_pkg::OP_AND: r = b & a;
        vfu_pkg::OP_OR:  r = b | a;
        vfu_pkg::OP_XOR: r = b ^ a;
        default:         r = '0;
      endcase
      res = res | ((r & mask) << (e * w));
    end
    return res;
  endfunction

  function automatic int word_count(input vfu_pkg::sew_t sew, input vfu_pkg::vlen_t vl);
    int per;
    per = 8 >> sew;
    return (int'(vl) + per - 1) / per;
  endfunction

  ////////////////////
  // Compare tasks
  task automatic check_word(input string name, input vfu_pkg::vrf_data_t got, exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_scalar(input string name, input vfu_pkg::elen_t got, exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input vfu_pkg::vfu_id_t got, exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input vfu_pkg::vreg_t got, exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    $display("Test %-10s %s", name, (err_cnt == errs_before) ? "ok" : "has errors");
  endtask

  ////////////////////
  // Drivers that start right after a rising edge
  task automatic send_req(input vfu_pkg::vfu_id_t id, input vfu_pkg::vfu_op_t op,
      input vfu_pkg::sew_t sew, input vfu_pkg::vlen_t vl, input vfu_pkg::vreg_t vs1, vs2, vd,
      input logic use_vs1, is_scalar, input vfu_pkg::elen_t rs1, rs2);
    int   cycles;
    logic taken;
    req_valid     <= 1'b1;
    req_id        <= id;
    req_op        <= op;
    req_sew       <= sew;
    req_vl        <= vl;
    req_vs1       <= vs1;
    req_vs2       <= vs2;
    req_vd        <= vd;
    req_use_vs1   <= use_vs1;
    req_is_scalar <= is_scalar;
    req_rs1       <= rs1;
    req_rs2       <= rs2;
    cycles = 0;
    taken  = 1'b0;
    while (!taken && cycles < TIMEOUT) begin
      @(negedge clk_i);
      taken = req_ready;
      @(posedge clk_i);
      cycles++;
    end
    req_valid <= 1'b0;
    if (!taken) begin
      err_cnt++;
      $display("Timeout: request with id %0d was never accepted", id);
    end
  endtask

  task automatic wait_cmpl(input int n);
    int cycles;
    cycles = 0;
    while (cmpl_ids.size() < n && cycles < TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (cmpl_ids.size() < n) begin
      err_cnt++;
      $display("Timeout: only %0d of %0d completions arrived", cmpl_ids.size(), n);
    end
    // Let the last VRF write settle
    @(posedge clk_i);
  endtask

  task automatic check_vector(input vfu_pkg::vfu_op_t op, input vfu_pkg::sew_t sew,
      input vfu_pkg::vlen_t vl, input vfu_pkg::vreg_t vs1, vs2, vd, input logic use_vs1,
      input vfu_pkg::elen_t rs1);
    int d, s1, s2;
    for (int w = 0; w < word_count(sew, vl); w++) begin
      d  = int'(vd) * vfu_pkg::WORDS_PER_VREG + w;
      s1 = int'(vs1) * vfu_pkg::WORDS_PER_VREG + w;
      s2 = int'(vs2) * vfu_pkg::WORDS_PER_VREG + w;
      check_word($sformatf("vrf_wdata_o at %0d", d), vrf_mem[d],
                 expect_word(op, sew, vrf_mem[s2], vrf_mem[s1], use_vs1, rs1));
    end
  endtask

  ////////////////////
  // Tests
  task automatic run_vector(input string name, input vfu_pkg::vfu_id_t id,
      input vfu_pkg::vfu_op_t op, input vfu_pkg::sew_t sew, input vfu_pkg::vlen_t vl,
      input vfu_pkg::vreg_t vs1, vs2, vd, input logic use_vs1, input vfu_pkg::elen_t rs1);
    int                 errs, spare;
    vfu_pkg::vrf_data_t spare_old;
    errs      = err_cnt;
    spare     = int'(vd) * vfu_pkg::WORDS_PER_VREG + word_count(sew, vl);
    spare_old = vrf_mem[spare];
    cmpl_ids.delete();
    send_req(id, op, sew, vl, vs1, vs2, vd, use_vs1, 1'b0, rs1, 32'd0);
    wait_cmpl(1);
    if (cmpl_ids.size() > 0) begin
      check_id("rsp_id_o", cmpl_ids[0], id);
    end
    check_vector(op, sew, vl, vs1, vs2, vd, use_vs1, rs1);
    // Word past the last one must keep its contents
    if (word_count(sew, vl) < vfu_pkg::WORDS_PER_VREG) begin
      check_word($sformatf("vrf_mem at %0d", spare), vrf_mem[spare], spare_old);
    end
    if (cmpl_ids.size() != 1) begin
      err_cnt++;
      $display("Expected one completion for id %0d but saw %0d", id, cmpl_ids.size());
    end
    report_test(name, errs);
  endtask

  task automatic run_scalar_xor();
    int             errs, cycles;
    vfu_pkg::elen_t rs1, rs2, held;
    errs = err_cnt;
    rng  = xorshift32(rng);
    rs1  = rng;
    rng  = xorshift32(rng);
    rs2  = rng;
    rsp_ready <= 1'b0;
    send_req(2'd2, vfu_pkg::OP_XOR, vfu_pkg::SEW_32, 6'd1, 5'd0, 5'd0, 5'd21, 1'b0, 1'b1,
             rs1, rs2);
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!rsp_valid && cycles < TIMEOUT);
    if (!rsp_valid) begin
      err_cnt++;
      $display("Timeout: scalar response never became valid");
    end
    held = rsp_result;
    repeat (10) begin
      @(negedge clk_i);
      check_bit("rsp_valid_o", rsp_valid, 1'b1);
      check_scalar("rsp_result_o", rsp_result, held);
    end
    @(posedge clk_i);
    rsp_ready <= 1'b1;
    @(negedge clk_i);
    check_scalar("rsp_result_o", rsp_result, rs2 ^ rs1);
    check_reg("rsp_rd_o", rsp_rd, 5'd21);
    check_id("rsp_id_o", rsp_id, 2'd2);
    check_bit("rsp_wb_o", rsp_wb, 1'b1);
    @(negedge clk_i);
    check_bit("rsp_valid_o", rsp_valid, 1'b0);
    @(posedge clk_i);
    report_test("scalar_xor", errs);
  endtask

  task automatic run_back_to_back();
    int             errs;
    vfu_pkg::elen_t rs1;
    errs = err_cnt;
    rng  = xorshift32(rng);
    rs1  = rng;
    stall_en <= 1'b1;
    cmpl_ids.delete();
    send_req(2'd1, vfu_pkg::OP_ADD, vfu_pkg::SEW_32, 6'd8, 5'd11, 5'd12, 5'd13, 1'b1, 1'b0,
             32'd0, 32'd0);
    send_req(2'd2, vfu_pkg::OP_SUB, vfu_pkg::SEW_16, 6'd16, 5'd0, 5'd14, 5'd15, 1'b0, 1'b0,
             rs1, 32'd0);
    send_req(2'd3, vfu_pkg::OP_XOR, vfu_pkg::SEW_8, 6'd32, 5'd16, 5'd17, 5'd18, 1'b1, 1'b0,
             32'd0, 32'd0);
    wait_cmpl(3);
    stall_en <= 1'b0;
    for (int i = 0; i < cmpl_ids.size() && i < 3; i++) begin
      check_id($sformatf("rsp_id_o completion %0d", i), cmpl_ids[i], vfu_pkg::vfu_id_t'(i + 1));
    end
    check_vector(vfu_pkg::OP_ADD, vfu_pkg::SEW_32, 6'd8, 5'd11, 5'd12, 5'd13, 1'b1, 32'd0);
    check_vector(vfu_pkg::OP_SUB, vfu_pkg::SEW_16, 6'd16, 5'd0, 5'd14, 5'd15, 1'b0, rs1);
    check_vector(vfu_pkg::OP_XOR, vfu_pkg::SEW_8, 6'd32, 5'd16, 5'd17, 5'd18, 1'b1, 32'd0);
    report_test("back2back", errs);
  endtask

  initial begin
    rst_n_i       <= 1'b0;
    req_valid     <= 1'b0;
    req_id        <= '0;
    req_op        <= '0;
    req_sew       <= '0;
    req_vl        <= '0;
    req_vs1       <= '0;
    req_vs2       <= '0;
    req_vd        <= '0;
    req_use_vs1   <= 1'b0;
    req_is_scalar <= 1'b0;
    req_rs1       <= '0;
    req_rs2       <= '0;
    rsp_ready     <= 1'b1;
    for (int i = 0; i < 128; i++) begin
      rng        = xorshift32(rng);
      vrf_mem[i] = {rng, xorshift32(rng ^ 32'(i))};
    end
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    // Idle outputs after reset
    @(negedge clk_i);
    check_bit("req_ready_o", req_ready, 1'b1);
    check_bit("vrf_we_o", vrf_we, 1'b0);
    check_bit("rsp_valid_o", rsp_valid, 1'b0);
    @(posedge clk_i);
    report_test("reset", 0);

    run_vector("add_vv32", 2'd0, vfu_pkg::OP_ADD, vfu_pkg::SEW_32, 6'd8, 5'd1, 5'd2, 5'd3,
               1'b1, 32'd0);
    rng = xorshift32(rng);
    run_vector("sub_vx8", 2'd1, vfu_pkg::OP_SUB, vfu_pkg::SEW_8, 6'd32, 5'd0, 5'd4, 5'd5,
               1'b0, rng);
    run_vector("and_vv16", 2'd2, vfu_pkg::OP_AND, vfu_pkg::SEW_16, 6'd5, 5'd9, 5'd10, 5'd6,
               1'b1, 32'd0);
    run_vector("or_vv16", 2'd3, vfu_pkg::OP_OR, vfu_pkg::SEW_16, 6'd5, 5'd9, 5'd10, 5'd7,
               1'b1, 32'd0);
    run_vector("xor_vv16", 2'd0, vfu_pkg::OP_XOR, vfu_pkg::SEW_16, 6'd5, 5'd9, 5'd10, 5'd8,
               1'b1, 32'd0);
    run_scalar_xor();
    run_back_to_back();

    $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
src/vfu_pkg.sv
src/vfu_op_queue.sv
src/vfu_sequencer.sv
src/vfu_operand_mux.sv
src/vfu_simd_alu.sv
src/vfu_writeback.sv
src/vfu_top.sv
verif/tb_vfu.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --top-module tb_vfu -f list.f -o tb_vfu \
  && ./obj_dir/tb_vfu > sim.log 2>&1 || true
[ -s sim.log ] || { echo "No simulation log, build or run failed"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
